// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module cpu_core_tb -Mdir obj_dir
	./obj_dir/Vcpu_core_tb | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== list.f ====
+incdir+logic
logic/cpu_pkg.sv
logic/instr_queue.sv
logic/controller.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_stage.sv
logic/cpu_core.sv
test/cpu_core_chk.sv
test/cpu_core_tb.sv

// ==== logic/controller.sv ====
`default_nettype none
`include "cpu_defs.svh"

module controller (
	input  logic [5:0] opcode,
	input  logic [4:0] sub_op_base,
	input  logic [7:0] sub_op_ls,
	output cpu_pkg::alu_src2_t select_alu_src2,
	output cpu_pkg::imm_ext_t select_imm_extend,
	output cpu_pkg::wb_sel_t select_write_reg,
	output cpu_pkg::alu_op_t alu_op,
	output logic do_dm_read,
	output logic do_dm_write,
	output logic do_reg_write
);
	import cpu_pkg::*;

	alu_op_t base_alu_op;

	always_comb begin
		case (sub_op_base)
			`SUB: base_alu_op = ALU_SUB;
			`AND: base_alu_op = ALU_AND;
			`OR: base_alu_op = ALU_OR;
			`XOR: base_alu_op = ALU_XOR;
			`SRLI: base_alu_op = ALU_SRL;
			`SLLI: base_alu_op = ALU_SLL;
			`ROTRI: base_alu_op = ALU_ROTR;
			default: base_alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		// no effect unless a case below claims the encoding
		select_alu_src2 = ALUSRC2_UNKNOWN;
		select_imm_extend = IMM_5BIT_ZE;
		select_write_reg = WRREG_UNKNOWN;
		alu_op = ALU_ADD;
		do_dm_read = 1'b0;
		do_dm_write = 1'b0;
		do_reg_write = 1'b0;
		case (opcode)
			`TY_BASE: begin
				case (sub_op_base)
					`ADD, `SUB, `AND, `OR, `XOR: begin
						select_alu_src2 = ALUSRC2_RBDATA;
						select_write_reg = WRREG_ALURESULT;
						alu_op = base_alu_op;
						do_reg_write = 1'b1;
					end
					// shift amount sits in the rb field
					`SRLI, `SLLI, `ROTRI: begin
						select_alu_src2 = ALUSRC2_IMM;
						select_imm_extend = IMM_5BIT_ZE;
						select_write_reg = WRREG_ALURESULT;
						alu_op = base_alu_op;
						do_reg_write = 1'b1;
					end
					default: begin
						do_reg_write = 1'b0;
					end
				endcase
			end
			`ADDI: begin
				select_alu_src2 = ALUSRC2_IMM;
				select_imm_extend = IMM_15BIT_SE;
				select_write_reg = WRREG_ALURESULT;
				do_reg_write = 1'b1;
			end
			`ORI: begin
				select_alu_src2 = ALUSRC2_IMM;
				select_imm_extend = IMM_15BIT_ZE;
				select_write_reg = WRREG_ALURESULT;
				alu_op = ALU_OR;
				do_reg_write = 1'b1;
			end
			`XORI: begin
				select_alu_src2 = ALUSRC2_IMM;
				select_imm_extend = IMM_15BIT_ZE;
				select_write_reg = WRREG_ALURESULT;
				alu_op = ALU_XOR;
				do_reg_write = 1'b1;
			end
			`MOVI: begin
				select_imm_extend = IMM_20BIT_SE;
				select_write_reg = WRREG_IMMDATA;
				do_reg_write = 1'b1;
			end
			`LWI: begin
				select_alu_src2 = ALUSRC2_LSWI;
				select_imm_extend = IMM_15BIT_SE;
				select_write_reg = WRREG_MEM;
				do_dm_read = 1'b1;
				do_reg_write = 1'b1;
			end
			`SWI: begin
				select_alu_src2 = ALUSRC2_LSWI;
				select_imm_extend = IMM_15BIT_SE;
				do_dm_write = 1'b1;
			end
			`TY_LS: begin
				case (sub_op_ls)
					`LW: begin
						select_alu_src2 = ALUSRC2_LSW;
						select_write_reg = WRREG_MEM;
						do_dm_read = 1'b1;
						do_reg_write = 1'b1;
					end
					`SW: begin
						select_alu_src2 = ALUSRC2_LSW;
						do_dm_write = 1'b1;
					end
					default: begin
						do_dm_write = 1'b0;
					end
				endcase
			end
			// branches and jumps retire as no-ops
			default: begin
				do_reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/cpu_core.sv ====
`default_nettype none

module cpu_core (
	input  logic clock,
	input  logic reset,
	input  logic in_valid,
	input  cpu_pkg::instr_t in_instr,
	output logic in_credit,
	output logic wb_valid,
	output cpu_pkg::reg_addr_t wb_reg,
	output cpu_pkg::word_t wb_data
);
	import cpu_pkg::*;

	logic q_valid;
	instr_t q_instr;
	logic q_pop;

	logic ex_valid;
	alu_op_t ex_alu_op;
	alu_src2_t ex_src2;
	wb_sel_t ex_wb_sel;
	logic ex_dm_read;
	logic ex_dm_write;
	reg_addr_t ex_rt;
	word_t ex_a;
	word_t ex_b;
	word_t ex_imm;
	word_t ex_rt_data;
	logic ex_fwd_valid;
	reg_addr_t ex_fwd_reg;
	word_t ex_fwd_data;
	logic ex_is_load;

	logic mem_valid;
	logic mem_reg_write;
	logic mem_dm_read;
	logic mem_dm_write;
	reg_addr_t mem_rt;
	word_t mem_result;
	word_t mem_store_data;
	logic mem_fwd_valid;
	reg_addr_t mem_fwd_reg;
	word_t mem_fwd_data;

	instr_queue queue (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_instr(in_instr),
		.q_pop(q_pop),
		.q_valid(q_valid),
		.q_instr(q_instr),
		.in_credit(in_credit)
	);

	decode_stage decode (
		.clock(clock),
		.reset(reset),
		.q_valid(q_valid),
		.q_instr(q_instr),
		.q_pop(q_pop),
		.ex_fwd_valid(ex_fwd_valid),
		.ex_fwd_reg(ex_fwd_reg),
		.ex_fwd_data(ex_fwd_data),
		.ex_is_load(ex_is_load),
		.mem_fwd_valid(mem_fwd_valid),
		.mem_fwd_reg(mem_fwd_reg),
		.mem_fwd_data(mem_fwd_data),
		.ex_valid(ex_valid),
		.ex_alu_op(ex_alu_op),
		.ex_src2(ex_src2),
		.ex_wb_sel(ex_wb_sel),
		.ex_dm_read(ex_dm_read),
		.ex_dm_write(ex_dm_write),
		.ex_rt(ex_rt),
		.ex_a(ex_a),
		.ex_b(ex_b),
		.ex_imm(ex_imm),
		.ex_rt_data(ex_rt_data)
	);

	execute_stage execute (
		.clock(clock),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_alu_op(ex_alu_op),
		.ex_src2(ex_src2),
		.ex_wb_sel(ex_wb_sel),
		.ex_dm_read(ex_dm_read),
		.ex_dm_write(ex_dm_write),
		.ex_rt(ex_rt),
		.ex_a(ex_a),
		.ex_b(ex_b),
		.ex_imm(ex_imm),
		.ex_rt_data(ex_rt_data),
		.ex_fwd_valid(ex_fwd_valid),
		.ex_fwd_reg(ex_fwd_reg),
		.ex_fwd_data(ex_fwd_data),
		.ex_is_load(ex_is_load),
		.mem_valid(mem_valid),
		.mem_reg_write(mem_reg_write),
		.mem_dm_read(mem_dm_read),
		.mem_dm_write(mem_dm_write),
		.mem_rt(mem_rt),
		.mem_result(mem_result),
		.mem_store_data(mem_store_data)
	);

	memory_stage memory (
		.clock(clock),
		.reset(reset),
		.mem_valid(mem_valid),
		.mem_reg_write(mem_reg_write),
		.mem_dm_read(mem_dm_read),
		.mem_dm_write(mem_dm_write),
		.mem_rt(mem_rt),
		.mem_result(mem_result),
		.mem_store_data(mem_store_data),
		.mem_fwd_valid(mem_fwd_valid),
		.mem_fwd_reg(mem_fwd_reg),
		.mem_fwd_data(mem_fwd_data),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

endmodule

`default_nettype wire

// ==== logic/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// major opcodes, bits 30:25
`define TY_BASE 6'b100000
`define ADDI    6'b101000
`define ORI     6'b101100
`define XORI    6'b101011
`define MOVI    6'b100010
`define LWI     6'b000010
`define SWI     6'b001010
`define TY_LS   6'b011100
`define TY_B    6'b100110
`define TY_J    6'b100100

// base format sub-ops, bits 4:0
`define ADD   5'b00000
`define SUB   5'b00001
`define AND   5'b00010
`define OR    5'b00100
`define XOR   5'b00011
`define SRLI  5'b01001
`define SLLI  5'b01000
`define ROTRI 5'b01011

// load/store format sub-ops, bits 7:0
`define LW 8'b00000010
`define SW 8'b00001010

`define QUEUE_DEPTH 4
`define DMEM_WORDS  256

`endif

// ==== logic/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;

	typedef struct packed {
		logic rsv;
		logic [5:0] opcode;
		reg_addr_t rt;
		reg_addr_t ra;
		reg_addr_t rb;
		logic [4:0] sh;
		logic [4:0] sub_op;
	} base_fmt_t;

	// also the LS format, with rb and sub_op in the low bits of imm15
	typedef struct packed {
		logic rsv;
		logic [5:0] opcode;
		reg_addr_t rt;
		reg_addr_t ra;
		logic [14:0] imm15;
	} imm_fmt_t;

	typedef struct packed {
		logic rsv;
		logic [5:0] opcode;
		reg_addr_t rt;
		logic [19:0] imm20;
	} movi_fmt_t;

	typedef union packed {
		base_fmt_t base;
		imm_fmt_t imm;
		movi_fmt_t movi;
	} instr_t;

	typedef enum logic [2:0] {
		ALUSRC2_RBDATA,
		ALUSRC2_IMM,
		ALUSRC2_LSWI,
		ALUSRC2_LSW,
		ALUSRC2_UNKNOWN
	} alu_src2_t;

	typedef enum logic [1:0] {
		IMM_5BIT_ZE,
		IMM_15BIT_SE,
		IMM_15BIT_ZE,
		IMM_20BIT_SE
	} imm_ext_t;

	typedef enum logic [1:0] {
		WRREG_ALURESULT,
		WRREG_IMMDATA,
		WRREG_MEM,
		WRREG_UNKNOWN
	} wb_sel_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SRL,
		ALU_SLL,
		ALU_ROTR
	} alu_op_t;

endpackage

`default_nettype wire

// ==== logic/decode_stage.sv ====
`default_nettype none

module decode_stage (
	input  logic clock,
	input  logic reset,
	input  logic q_valid,
	input  cpu_pkg::instr_t q_instr,
	output logic q_pop,
	input  logic ex_fwd_valid,
	input  cpu_pkg::reg_addr_t ex_fwd_reg,
	input  cpu_pkg::word_t ex_fwd_data,
	input  logic ex_is_load,
	input  logic mem_fwd_valid,
	input  cpu_pkg::reg_addr_t mem_fwd_reg,
	input  cpu_pkg::word_t mem_fwd_data,
	output logic ex_valid,
	output cpu_pkg::alu_op_t ex_alu_op,
	output cpu_pkg::alu_src2_t ex_src2,
	output cpu_pkg::wb_sel_t ex_wb_sel,
	output logic ex_dm_read,
	output logic ex_dm_write,
	output cpu_pkg::reg_addr_t ex_rt,
	output cpu_pkg::word_t ex_a,
	output cpu_pkg::word_t ex_b,
	output cpu_pkg::word_t ex_imm,
	output cpu_pkg::word_t ex_rt_data
);
	import cpu_pkg::*;

	reg_addr_t rt;
	reg_addr_t ra;
	reg_addr_t rb;
	alu_src2_t select_alu_src2;
	imm_ext_t select_imm_extend;
	wb_sel_t select_write_reg;
	alu_op_t alu_op;
	logic do_dm_read;
	logic do_dm_write;
	logic do_reg_write;
	word_t rf_ra_data;
	word_t rf_rb_data;
	word_t rf_rt_data;
	word_t a_data;
	word_t b_data;
	word_t rt_data;
	word_t imm_data;
	logic uses_ra;
	logic uses_rb;
	logic uses_rt;
	logic stall;

	// newest producer wins
	function automatic word_t forward(input reg_addr_t src, input word_t rf_data);
		if (ex_fwd_valid && ex_fwd_reg == src)
			return ex_fwd_data;
		if (mem_fwd_valid && mem_fwd_reg == src)
			return mem_fwd_data;
		return rf_data;
	endfunction

	assign rt = q_instr.base.rt;
	assign ra = q_instr.base.ra;
	assign rb = q_instr.base.rb;

	controller ctrl (
		.opcode(q_instr.base.opcode),
		.sub_op_base(q_instr.base.sub_op),
		.sub_op_ls(q_instr.imm.imm15[7:0]),
		.select_alu_src2(select_alu_src2),
		.select_imm_extend(select_imm_extend),
		.select_write_reg(select_write_reg),
		.alu_op(alu_op),
		.do_dm_read(do_dm_read),
		.do_dm_write(do_dm_write),
		.do_reg_write(do_reg_write)
	);

	// second copy of the file gives stores a port for rt
	reg_file rf_ops (
		.clock(clock),
		.reset(reset),
		.ra_addr(ra),
		.rb_addr(rb),
		.ra_data(rf_ra_data),
		.rb_data(rf_rb_data),
		.we(mem_fwd_valid),
		.wr_addr(mem_fwd_reg),
		.wr_data(mem_fwd_data)
	);

	reg_file rf_store (
		.clock(clock),
		.reset(reset),
		.ra_addr(rt),
		.rb_addr(rt),
		.ra_data(rf_rt_data),
		.rb_data(),
		.we(mem_fwd_valid),
		.wr_addr(mem_fwd_reg),
		.wr_data(mem_fwd_data)
	);

	assign uses_ra = (do_reg_write && select_write_reg != WRREG_IMMDATA) || do_dm_write;
	assign uses_rb = (select_alu_src2 == ALUSRC2_RBDATA) || (select_alu_src2 == ALUSRC2_LSW);
	assign uses_rt = do_dm_write;

	// load result not ready until it reaches memory stage
	assign stall = q_valid && ex_is_load &&
		((uses_ra && ex_fwd_reg == ra) ||
		(uses_rb && ex_fwd_reg == rb) ||
		(uses_rt && ex_fwd_reg == rt));
	assign q_pop = q_valid && !stall;

	always_comb begin
		a_data = forward(ra, rf_ra_data);
		b_data = forward(rb, rf_rb_data);
		rt_data = forward(rt, rf_rt_data);
	end

	always_comb begin
		case (select_imm_extend)
			IMM_5BIT_ZE: imm_data = {27'b0, q_instr.base.rb};
			IMM_15BIT_SE: imm_data = {{17{q_instr.imm.imm15[14]}}, q_instr.imm.imm15};
			IMM_15BIT_ZE: imm_data = {17'b0, q_instr.imm.imm15};
			default: imm_data = {{12{q_instr.movi.imm20[19]}}, q_instr.movi.imm20};
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			ex_valid <= 1'b0;
			ex_dm_read <= 1'b0;
			ex_dm_write <= 1'b0;
		end else begin
			// bubble while stalled
			ex_valid <= q_pop;
			ex_dm_read <= do_dm_read;
			ex_dm_write <= do_dm_write;
		end
	end

	always_ff @(posedge clock) begin
		ex_alu_op <= alu_op;
		ex_src2 <= select_alu_src2;
		ex_wb_sel <= do_reg_write ? select_write_reg : WRREG_UNKNOWN;
		ex_rt <= rt;
		ex_a <= a_data;
		ex_b <= b_data;
		ex_imm <= imm_data;
		ex_rt_data <= rt_data;
	end

endmodule

`default_nettype wire

// ==== logic/execute_stage.sv ====
`default_nettype none

module execute_stage (
	input  logic clock,
	input  logic reset,
	input  logic ex_valid,
	input  cpu_pkg::alu_op_t ex_alu_op,
	input  cpu_pkg::alu_src2_t ex_src2,
	input  cpu_pkg::wb_sel_t ex_wb_sel,
	input  logic ex_dm_read,
	input  logic ex_dm_write,
	input  cpu_pkg::reg_addr_t ex_rt,
	input  cpu_pkg::word_t ex_a,
	input  cpu_pkg::word_t ex_b,
	input  cpu_pkg::word_t ex_imm,
	input  cpu_pkg::word_t ex_rt_data,
	output logic ex_fwd_valid,
	output cpu_pkg::reg_addr_t ex_fwd_reg,
	output cpu_pkg::word_t ex_fwd_data,
	output logic ex_is_load,
	output logic mem_valid,
	output logic mem_reg_write,
	output logic mem_dm_read,
	output logic mem_dm_write,
	output cpu_pkg::reg_addr_t mem_rt,
	output cpu_pkg::word_t mem_result,
	output cpu_pkg::word_t mem_store_data
);
	import cpu_pkg::*;

	word_t operand_b;
	word_t alu_result;
	word_t result;
	logic [4:0] shamt;
	logic reg_write;

	always_comb begin
		case (ex_src2)
			ALUSRC2_RBDATA: operand_b = ex_b;
			ALUSRC2_IMM: operand_b = ex_imm;
			// word offset
			ALUSRC2_LSWI: operand_b = ex_imm << 2;
			ALUSRC2_LSW: operand_b = ex_b;
			default: operand_b = '0;
		endcase
	end

	assign shamt = operand_b[4:0];

	always_comb begin
		case (ex_alu_op)
			ALU_ADD: alu_result = ex_a + operand_b;
			ALU_SUB: alu_result = ex_a - operand_b;
			ALU_AND: alu_result = ex_a & operand_b;
			ALU_OR: alu_result = ex_a | operand_b;
			ALU_XOR: alu_result = ex_a ^ operand_b;
			ALU_SRL: alu_result = ex_a >> shamt;
			ALU_SLL: alu_result = ex_a << shamt;
			default: alu_result = (ex_a >> shamt) | (ex_a << (6'd32 - {1'b0, shamt}));
		endcase
	end

	assign result = (ex_wb_sel == WRREG_IMMDATA) ? ex_imm : alu_result;
	assign reg_write = (ex_wb_sel != WRREG_UNKNOWN);

	// loads have no value yet, decode stalls on them instead
	assign ex_fwd_valid = ex_valid && reg_write && !ex_dm_read;
	assign ex_fwd_reg = ex_rt;
	assign ex_fwd_data = result;
	assign ex_is_load = ex_valid && ex_dm_read;

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_valid <= 1'b0;
			mem_reg_write <= 1'b0;
			mem_dm_read <= 1'b0;
			mem_dm_write <= 1'b0;
		end else begin
			mem_valid <= ex_valid;
			mem_reg_write <= ex_valid && reg_write;
			mem_dm_read <= ex_valid && ex_dm_read;
			mem_dm_write <= ex_valid && ex_dm_write;
		end
	end

	always_ff @(posedge clock) begin
		mem_rt <= ex_rt;
		mem_result <= result;
		mem_store_data <= ex_rt_data;
	end

endmodule

`default_nettype wire

// ==== logic/instr_queue.sv ====
`default_nettype none
`include "cpu_defs.svh"

module instr_queue (
	input  logic clock,
	input  logic reset,
	input  logic in_valid,
	input  cpu_pkg::instr_t in_instr,
	input  logic q_pop,
	output logic q_valid,
	output cpu_pkg::instr_t q_instr,
	output logic in_credit
);
	import cpu_pkg::*;

	localparam int PTR_W = $clog2(`QUEUE_DEPTH);
	localparam logic [PTR_W-1:0] LAST = PTR_W'(`QUEUE_DEPTH - 1);

	instr_t entries [`QUEUE_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic do_pop;

	assign q_valid = (count != '0);
	assign q_instr = entries[rd_ptr];
	assign do_pop = q_pop && q_valid;

	// credit flow guarantees a free slot on every push
	always_ff @(posedge clock) begin
		if (in_valid)
			entries[wr_ptr] <= in_instr;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_credit <= 1'b0;
		end else begin
			if (in_valid)
				wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
			count <= count + {{PTR_W{1'b0}}, in_valid} - {{PTR_W{1'b0}}, do_pop};
			// one credit back per freed entry
			in_credit <= do_pop;
		end
	end

endmodule

`default_nettype wire

// ==== logic/memory_stage.sv ====
`default_nettype none
`include "cpu_defs.svh"

module memory_stage (
	input  logic clock,
	input  logic reset,
	input  logic mem_valid,
	input  logic mem_reg_write,
	input  logic mem_dm_read,
	input  logic mem_dm_write,
	input  cpu_pkg::reg_addr_t mem_rt,
	input  cpu_pkg::word_t mem_result,
	input  cpu_pkg::word_t mem_store_data,
	output logic mem_fwd_valid,
	output cpu_pkg::reg_addr_t mem_fwd_reg,
	output cpu_pkg::word_t mem_fwd_data,
	output logic wb_valid,
	output cpu_pkg::reg_addr_t wb_reg,
	output cpu_pkg::word_t wb_data
);
	import cpu_pkg::*;

	localparam int DM_AW = $clog2(`DMEM_WORDS);

	word_t dmem [`DMEM_WORDS];
	logic [DM_AW-1:0] dm_addr;

	// word addressed
	assign dm_addr = mem_result[DM_AW+1:2];

	always_ff @(posedge clock) begin
		if (mem_valid && mem_dm_write)
			dmem[dm_addr] <= mem_store_data;
	end

	// also the register file write port
	assign mem_fwd_valid = mem_valid && mem_reg_write;
	assign mem_fwd_reg = mem_rt;
	assign mem_fwd_data = mem_dm_read ? dmem[dm_addr] : mem_result;

	always_ff @(posedge clock) begin
		if (reset)
			wb_valid <= 1'b0;
		else
			wb_valid <= mem_fwd_valid;
	end

	always_ff @(posedge clock) begin
		wb_reg <= mem_fwd_reg;
		wb_data <= mem_fwd_data;
	end

endmodule

`default_nettype wire

// ==== logic/reg_file.sv ====
`default_nettype none

module reg_file (
	input  logic clock,
	input  logic reset,
	input  cpu_pkg::reg_addr_t ra_addr,
	input  cpu_pkg::reg_addr_t rb_addr,
	output cpu_pkg::word_t ra_data,
	output cpu_pkg::word_t rb_data,
	input  logic we,
	input  cpu_pkg::reg_addr_t wr_addr,
	input  cpu_pkg::word_t wr_data
);
	import cpu_pkg::*;

	word_t regs [32];

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

`default_nettype wire

// ==== test/cpu_core_chk.sv ====
`default_nettype none
`include "cpu_defs.svh"

module cpu_core_chk (
	input logic clock,
	input logic reset,
	input logic in_valid,
	input logic in_credit,
	input logic q_valid,
	input logic q_pop,
	input logic wb_valid
);
	logic [3:0] occupancy;
	logic stall;

	assign stall = q_valid && !q_pop;

	// entries pushed minus entries popped
	always_ff @(posedge clock) begin
		if (reset)
			occupancy <= '0;
		else
			occupancy <= occupancy + 4'(in_valid) - 4'(q_valid && q_pop);
	end

	occupancy_bound: assert property (@(posedge clock) disable iff (reset)
		occupancy <= `QUEUE_DEPTH)
		else $error("queue holds more entries than its depth");

	quiet_in_reset: assert property (@(posedge clock)
		(reset && $past(reset)) |-> (!in_credit && !wb_valid))
		else $error("credit or write-back seen while reset is high");

	single_cycle_stall: assert property (@(posedge clock) disable iff (reset)
		stall |=> !stall)
		else $error("decode stalled for more than one cycle");

endmodule

bind cpu_core cpu_core_chk chk_i (
	.clock(clock),
	.reset(reset),
	.in_valid(in_valid),
	.in_credit(in_credit),
	.q_valid(q_valid),
	.q_pop(q_pop),
	.wb_valid(wb_valid)
);

`default_nettype wire

// ==== test/cpu_core_tb.sv ====
`default_nettype none
`include "cpu_defs.svh"

module cpu_core_tb;
	import cpu_pkg::*;

	localparam int PROGRAM_LEN = 280;
	localparam int WAIT_LIMIT = 2000;

	logic clock;
	logic reset;
	logic in_valid;
	instr_t in_instr;
	logic in_credit;
	logic wb_valid;
	reg_addr_t wb_reg;
	word_t wb_data;

	word_t model_regs [32];
	word_t model_mem [`DMEM_WORDS];
	reg_addr_t exp_reg_q [$];
	word_t exp_data_q [$];
	instr_t prog [$];
	logic [31:0] rng_state;
	int credits;

	cpu_core cpu_core_i (
		.clock(clock),
		.reset(reset),
		.in_valid(in_valid),
		.in_instr(in_instr),
		.in_credit(in_credit),
		.wb_valid(wb_valid),
		.wb_reg(wb_reg),
		.wb_data(wb_data)
	);

	always #5 clock = ~clock;

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic check_reg(input reg_addr_t actual, input reg_addr_t expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0t: wb_reg expected %0d, actual %0d",
				$time, expected, actual));
	endtask

	task automatic check_data(input word_t actual, input word_t expected);
		if (actual !== expected)
			report_failure($sformatf("mismatch at %0t: wb_data expected %h, actual %h",
				$time, expected, actual));
	endtask

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rng_state = x;
		return x;
	endfunction

	function automatic word_t sext15(input logic [14:0] imm);
		return {{17{imm[14]}}, imm};
	endfunction

	function automatic word_t rotate_right(input word_t value, input logic [4:0] amount);
		logic [63:0] doubled;
		doubled = {value, value} >> amount;
		return doubled[31:0];
	endfunction

	function automatic int word_index(input word_t addr);
		return int'((addr >> 2) % `DMEM_WORDS);
	endfunction

	// ISA model, one call per instruction in program order
	function automatic void ref_exec(input instr_t ins);
		word_t a;
		word_t b;
		word_t res;
		word_t addr;
		reg_addr_t rt;
		logic writes;
		a = model_regs[ins.base.ra];
		b = model_regs[ins.base.rb];
		rt = ins.base.rt;
		res = '0;
		writes = 1'b0;
		case (ins.base.opcode)
			`TY_BASE: begin
				writes = 1'b1;
				case (ins.base.sub_op)
					`ADD: res = a + b;
					`SUB: res = a - b;
					`AND: res = a & b;
					`OR: res = a | b;
					`XOR: res = a ^ b;
					// shift amount is the rb field itself
					`SRLI: res = a >> ins.base.rb;
					`SLLI: res = a << ins.base.rb;
					`ROTRI: res = rotate_right(a, ins.base.rb);
					default: writes = 1'b0;
				endcase
			end
			`ADDI: begin
				res = a + sext15(ins.imm.imm15);
				writes = 1'b1;
			end
			`ORI: begin
				res = a | {17'b0, ins.imm.imm15};
				writes = 1'b1;
			end
			`XORI: begin
				res = a ^ {17'b0, ins.imm.imm15};
				writes = 1'b1;
			end
			`MOVI: begin
				res = {{12{ins.movi.imm20[19]}}, ins.movi.imm20};
				writes = 1'b1;
			end
			`LWI: begin
				addr = a + (sext15(ins.imm.imm15) << 2);
				res = model_mem[word_index(addr)];
				writes = 1'b1;
			end
			`SWI: begin
				addr = a + (sext15(ins.imm.imm15) << 2);
				model_mem[word_index(addr)] = model_regs[rt];
			end
			`TY_LS: begin
				addr = a + b;
				if (ins.imm.imm15[7:0] == `LW) begin
					res = model_mem[word_index(addr)];
					writes = 1'b1;
				end else if (ins.imm.imm15[7:0] == `SW) begin
					model_mem[word_index(addr)] = model_regs[rt];
				end
			end
			default: begin
				// branches, jumps and unknown opcodes leave no trace
				writes = 1'b0;
			end
		endcase
		if (writes) begin
			model_regs[rt] = res;
			exp_reg_q.push_back(rt);
			exp_data_q.push_back(res);
		end
	endfunction

	function automatic instr_t base_instr(input logic [4:0] sub, input reg_addr_t rt,
			input reg_addr_t ra, input reg_addr_t rb);
		instr_t ins;
		ins = '0;
		ins.base.opcode = `TY_BASE;
		ins.base.rt = rt;
		ins.base.ra = ra;
		ins.base.rb = rb;
		ins.base.sub_op = sub;
		return ins;
	endfunction

	function automatic instr_t imm_instr(input logic [5:0] op, input reg_addr_t rt,
			input reg_addr_t ra, input logic [14:0] imm15);
		instr_t ins;
		ins = '0;
		ins.imm.opcode = op;
		ins.imm.rt = rt;
		ins.imm.ra = ra;
		ins.imm.imm15 = imm15;
		return ins;
	endfunction

	function automatic instr_t ls_instr(input logic [7:0] sub, input reg_addr_t rt,
			input reg_addr_t ra, input reg_addr_t rb);
		return imm_instr(`TY_LS, rt, ra, {rb, 2'b00, sub});
	endfunction

	function automatic instr_t movi_instr(input reg_addr_t rt, input logic [19:0] imm20);
		instr_t ins;
		ins = '0;
		ins.movi.opcode = `MOVI;
		ins.movi.rt = rt;
		ins.movi.imm20 = imm20;
		return ins;
	endfunction

	// r1..r3 favoured so that hazards show up often
	function automatic reg_addr_t pick_reg();
		if (xorshift32() % 2 == 0)
			return reg_addr_t'(1 + xorshift32() % 3);
		return reg_addr_t'(1 + xorshift32() % 7);
	endfunction

	function automatic reg_addr_t pick_base();
		return reg_addr_t'(30 + xorshift32() % 2);
	endfunction

	function automatic instr_t random_instr();
		logic [31:0] kind;
		logic [4:0] sub;
		instr_t ins;
		kind = xorshift32() % 20;
		sub = `ADD;
		ins = '0;
		case (kind)
			0, 1, 2, 3, 4, 5: begin
				case (xorshift32() % 5)
					0: sub = `ADD;
					1: sub = `SUB;
					2: sub = `AND;
					3: sub = `OR;
					default: sub = `XOR;
				endcase
				ins = base_instr(sub, pick_reg(), pick_reg(), pick_reg());
			end
			6, 7: begin
				case (xorshift32() % 3)
					0: sub = `SRLI;
					1: sub = `SLLI;
					default: sub = `ROTRI;
				endcase
				ins = base_instr(sub, pick_reg(), pick_reg(), reg_addr_t'(xorshift32() % 32));
			end
			9: ins = imm_instr(`ORI, pick_reg(), pick_reg(), 15'(xorshift32()));
			10: ins = imm_instr(`XORI, pick_reg(), pick_reg(), 15'(xorshift32()));
			11: ins = movi_instr(pick_reg(), 20'(xorshift32()));
			12, 13: ins = imm_instr(`LWI, pick_reg(), pick_base(), 15'(xorshift32() % 8));
			14: ins = imm_instr(`SWI, pick_reg(), pick_base(), 15'(xorshift32() % 8));
			15: ins = ls_instr(`LW, pick_reg(), pick_base(), reg_addr_t'(28 + xorshift32() % 2));
			16: ins = ls_instr(`SW, pick_reg(), pick_base(), reg_addr_t'(28 + xorshift32() % 2));
			17: begin
				ins = xorshift32();
				ins.base.rsv = 1'b0;
				ins.base.opcode = (xorshift32() % 2 == 0) ? `TY_B : `TY_J;
			end
			18: begin
				case (xorshift32() % 3)
					0: ins = base_instr(5'b11111, pick_reg(), pick_reg(), pick_reg());
					1: ins = ls_instr(8'hff, pick_reg(), pick_base(), 5'd28);
					default: ins = movi_instr(pick_reg(), 20'(xorshift32()));
				endcase
				if (ins.base.opcode == `MOVI)
					ins.base.opcode = 6'b111111;
			end
			default: ins = imm_instr(`ADDI, pick_reg(), pick_reg(), 15'(xorshift32()));
		endcase
		return ins;
	endfunction

	function automatic void emit(input instr_t ins);
		prog.push_back(ins);
		ref_exec(ins);
	endfunction

	function automatic void generate_program();
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		// base and offset registers, never written again
		emit(movi_instr(5'd28, 20'h00000));
		emit(movi_instr(5'd29, 20'h00008));
		emit(movi_instr(5'd30, 20'h00040));
		emit(movi_instr(5'd31, 20'h00080));
		for (int k = 1; k < 8; k++)
			emit(movi_instr(reg_addr_t'(k), 20'(xorshift32())));
		// fill both load windows before any load reads them
		for (int off = 0; off < 8; off++) begin
			emit(imm_instr(`SWI, reg_addr_t'(1 + off % 7), 5'd30, 15'(off)));
			emit(imm_instr(`SWI, reg_addr_t'(1 + (off + 3) % 7), 5'd31, 15'(off)));
		end
		for (int i = 0; i < PROGRAM_LEN; i++)
			emit(random_instr());
	endfunction

	task automatic send_program();
		int gap;
		int waited;
		for (int i = 0; i < prog.size(); i++) begin
			gap = (xorshift32() % 4 == 0) ? int'(xorshift32() % 3) + 1 : 0;
			repeat (gap) begin
				in_valid <= 1'b0;
				@(posedge clock);
			end
			waited = 0;
			while (credits == 0) begin
				in_valid <= 1'b0;
				@(posedge clock);
				waited++;
				if (waited > WAIT_LIMIT)
					report_failure("sender timed out waiting for a credit");
			end
			in_valid <= 1'b1;
			in_instr <= prog[i];
			credits--;
			@(posedge clock);
		end
		in_valid <= 1'b0;
	endtask

	task automatic wait_for_drain();
		int waited;
		waited = 0;
		while (exp_reg_q.size() != 0) begin
			@(posedge clock);
			waited++;
			if (waited > WAIT_LIMIT)
				report_failure("instructions did not retire before the timeout");
		end
	endtask

	task automatic wait_for_credits();
		int waited;
		waited = 0;
		while (credits != `QUEUE_DEPTH) begin
			@(posedge clock);
			waited++;
			if (waited > WAIT_LIMIT)
				report_failure("credits were not all returned before the timeout");
		end
	endtask

	// credit returns, sampled mid-cycle
	always @(negedge clock) begin
		if (reset)
			credits = `QUEUE_DEPTH;
		else if (in_credit) begin
			if (credits >= `QUEUE_DEPTH)
				report_failure("credit returned beyond the queue depth");
			else
				credits++;
		end
	end

	always @(negedge clock) begin
		if (!reset && wb_valid) begin
			if (exp_reg_q.size() == 0) begin
				report_failure("write-back with no instruction left to retire");
			end else begin
				check_reg(wb_reg, exp_reg_q.pop_front());
				check_data(wb_data, exp_data_q.pop_front());
			end
		end
	end

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		in_valid = 1'b0;
		in_instr = '0;
		credits = `QUEUE_DEPTH;
		rng_state = 32'd55393;
		generate_program();
		repeat (5) @(posedge clock);
		reset <= 1'b0;
		send_program();
		wait_for_drain();
		wait_for_credits();
		// last popped instruction reaches write-back three cycles after its pop
		repeat (3) @(posedge clock);
		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire
